//--- source/video_timing_pkg.sv
package video_timing_pkg;

	// Wide enough for 800 pixels and 525 lines
	localparam int COUNTER_WIDTH = 11;

	// 640x480 at 60 Hz, 25.175 MHz pixel clock
	// Horizontal lengths in pixels
	localparam int H_FRONT_PORCH = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK_PORCH = 48;
	localparam int H_VISIBLE = 640;

	// Vertical lengths in lines
	localparam int V_FRONT_PORCH = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK_PORCH = 33;
	localparam int V_VISIBLE = 480;

endpackage

//--- source/framebuffer_pkg.sv
package framebuffer_pkg;

	// One frame buffer word
	localparam int WORD_WIDTH = 16;

	// Palette addressing
	localparam int PALETTE_INDEX_WIDTH = 8;
	localparam int PALETTE_DEPTH = 2 ** PALETTE_INDEX_WIDTH;

	// Direct color, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Two palette indices, low byte shown first
	typedef struct packed {
		logic [PALETTE_INDEX_WIDTH-1:0] second;
		logic [PALETTE_INDEX_WIDTH-1:0] first;
	} index_pair_t;

	// Same word, read as one pixel or two indices
	typedef union packed {
		rgb565_t direct;
		index_pair_t indexed;
	} fb_word_t;

endpackage

//--- source/vga_timing_generator.sv
module vga_timing_generator #(
	parameter int HSYNC_START = video_timing_pkg::H_FRONT_PORCH,
	parameter int HSYNC_END = HSYNC_START + video_timing_pkg::H_SYNC,
	parameter int HVISIBLE_START = HSYNC_END + video_timing_pkg::H_BACK_PORCH,
	parameter int HVISIBLE_END = HVISIBLE_START + video_timing_pkg::H_VISIBLE,
	parameter int VSYNC_START = video_timing_pkg::V_FRONT_PORCH,
	parameter int VSYNC_END = VSYNC_START + video_timing_pkg::V_SYNC,
	parameter int VVISIBLE_START = VSYNC_END + video_timing_pkg::V_BACK_PORCH,
	parameter int VVISIBLE_END = VVISIBLE_START + video_timing_pkg::V_VISIBLE
) (
	input logic clk,
	input logic reset,
	output logic vga_hs,
	output logic vga_vs,
	output logic in_visible_region,
	output logic pixel_enable
);
	import video_timing_pkg::*;

	// Boundaries at counter width
	localparam logic [COUNTER_WIDTH-1:0] HS_START_COUNT = COUNTER_WIDTH'(HSYNC_START);
	localparam logic [COUNTER_WIDTH-1:0] HS_END_COUNT = COUNTER_WIDTH'(HSYNC_END);
	localparam logic [COUNTER_WIDTH-1:0] HV_START_COUNT = COUNTER_WIDTH'(HVISIBLE_START);
	localparam logic [COUNTER_WIDTH-1:0] HV_END_COUNT = COUNTER_WIDTH'(HVISIBLE_END);
	localparam logic [COUNTER_WIDTH-1:0] VS_START_COUNT = COUNTER_WIDTH'(VSYNC_START);
	localparam logic [COUNTER_WIDTH-1:0] VS_END_COUNT = COUNTER_WIDTH'(VSYNC_END);
	localparam logic [COUNTER_WIDTH-1:0] VV_START_COUNT = COUNTER_WIDTH'(VVISIBLE_START);
	// Last line of the frame is the last visible one
	localparam logic [COUNTER_WIDTH-1:0] V_LAST_LINE = COUNTER_WIDTH'(VVISIBLE_END - 1);

	logic [COUNTER_WIDTH-1:0] horizontal_counter;
	logic [COUNTER_WIDTH-1:0] vertical_counter;
	logic hvisible;
	logic vvisible;
	logic line_end;
	logic frame_end;

	assign in_visible_region = hvisible && vvisible;
	assign line_end = horizontal_counter == HV_END_COUNT;
	assign frame_end = vertical_counter == V_LAST_LINE;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pixel_enable <= 1'b0;
			horizontal_counter <= '0;
			vertical_counter <= '0;
			hvisible <= 1'b0;
			vvisible <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end
		else
		begin
			// Pixel rate is half of clk
			pixel_enable <= !pixel_enable;
			if (pixel_enable)
			begin
				// Line wrap, then frame wrap
				if (line_end)
				begin
					horizontal_counter <= '0;
					hvisible <= 1'b0;
					if (frame_end)
					begin
						vertical_counter <= '0;
						vvisible <= 1'b0;
					end
					else
						vertical_counter <= vertical_counter + 1'b1;
				end
				else
					horizontal_counter <= horizontal_counter + 1'b1;

				// Vertical sync pulse, then visible lines
				if (vertical_counter == VS_START_COUNT)
					vga_vs <= 1'b0;
				else if (vertical_counter == VS_END_COUNT)
					vga_vs <= 1'b1;
				else if (vertical_counter == VV_START_COUNT)
					vvisible <= 1'b1;

				// Horizontal sync pulse, then visible pixels
				if (horizontal_counter == HS_START_COUNT)
					vga_hs <= 1'b0;
				else if (horizontal_counter == HS_END_COUNT)
					vga_hs <= 1'b1;
				else if (horizontal_counter == HV_START_COUNT)
					hvisible <= 1'b1;
			end
		end
	end

endmodule

//--- source/framebuffer_ram.sv
module framebuffer_ram #(
	parameter int FB_ADDR_WIDTH = 19
) (
	input logic clk,
	input logic [FB_ADDR_WIDTH-1:0] address,
	input logic write_enable,
	input logic [framebuffer_pkg::WORD_WIDTH-1:0] write_data,
	output logic [framebuffer_pkg::WORD_WIDTH-1:0] read_data
);
	import framebuffer_pkg::*;

	// Whole frame, one word per entry
	logic [WORD_WIDTH-1:0] memory [2 ** FB_ADDR_WIDTH];

	always_ff @(posedge clk)
	begin
		// Single port, write wins the entry
		if (write_enable)
			memory[address] <= write_data;
		// Read every cycle, old data on a write
		read_data <= memory[address];
	end

endmodule

//--- source/framebuffer_arbiter.sv
module framebuffer_arbiter #(
	parameter int FB_ADDR_WIDTH = 19
) (
	input logic fetch_request,
	input logic [FB_ADDR_WIDTH-1:0] fetch_address,
	input logic write_request,
	input logic [FB_ADDR_WIDTH-1:0] write_address,
	input logic [framebuffer_pkg::WORD_WIDTH-1:0] write_data,
	output logic fetch_grant,
	output logic write_grant,
	output logic [FB_ADDR_WIDTH-1:0] ram_address,
	output logic ram_write_enable,
	output logic [framebuffer_pkg::WORD_WIDTH-1:0] ram_write_data
);

	always_comb
	begin
		// Scanout first, never stalled
		fetch_grant = fetch_request;
		// Host write only on a free cycle
		write_grant = write_request && !fetch_request;

		// Idle port points at the fetch address
		if (write_grant)
			ram_address = write_address;
		else
			ram_address = fetch_address;

		ram_write_enable = write_grant;
		// Data only when the write owns the port
		if (write_grant)
			ram_write_data = write_data;
		else
			ram_write_data = '0;
	end

endmodule

//--- source/host_write_port.sv
module host_write_port #(
	parameter int FB_ADDR_WIDTH = 19,
	localparam int HOST_ADDR_WIDTH =
		(FB_ADDR_WIDTH > framebuffer_pkg::PALETTE_INDEX_WIDTH) ?
		FB_ADDR_WIDTH : framebuffer_pkg::PALETTE_INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic host_write,
	input logic host_select,
	input logic [HOST_ADDR_WIDTH-1:0] host_address,
	input logic [framebuffer_pkg::WORD_WIDTH-1:0] host_data,
	input logic write_grant,
	output logic write_pending,
	output logic write_request,
	output logic [FB_ADDR_WIDTH-1:0] write_address,
	output framebuffer_pkg::fb_word_t write_data,
	output logic palette_write,
	output logic [framebuffer_pkg::PALETTE_INDEX_WIDTH-1:0] palette_index,
	output framebuffer_pkg::rgb565_t palette_color
);
	import framebuffer_pkg::*;

	fb_word_t host_word;
	logic accept;
	logic fb_capture;

	assign host_word = host_data;
	// Strobes dropped while a write waits
	assign accept = host_write && !write_pending;
	assign fb_capture = accept && !host_select;

	// Palette entries pass straight through
	assign palette_write = accept && host_select;
	assign palette_index = host_address[PALETTE_INDEX_WIDTH-1:0];
	assign palette_color = host_word.direct;

	assign write_request = write_pending;

	// Holding register full flag
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			write_pending <= 1'b0;
		else if (fb_capture)
			write_pending <= 1'b1;
		else if (write_grant)
			write_pending <= 1'b0;
	end

	// Held address and data
	always_ff @(posedge clk)
	begin
		if (fb_capture)
		begin
			write_address <= host_address[FB_ADDR_WIDTH-1:0];
			write_data <= host_word;
		end
	end

endmodule

//--- source/scanout_fetch.sv
module scanout_fetch #(
	parameter int FB_ADDR_WIDTH = 19
) (
	input logic clk,
	input logic reset,
	input logic pixel_enable,
	input logic in_visible_region,
	input logic vga_vs,
	input logic palette_mode,
	input logic fetch_grant,
	input logic [framebuffer_pkg::WORD_WIDTH-1:0] read_data,
	output logic fetch_request,
	output logic [FB_ADDR_WIDTH-1:0] fetch_address,
	output framebuffer_pkg::fb_word_t fetch_word,
	output logic fetch_word_valid
);
	import framebuffer_pkg::*;

	logic [FB_ADDR_WIDTH-1:0] word_address;
	logic high_half;
	logic need_word;
	logic read_pending;
	logic word_held;
	fb_word_t held_word;

	// Palette mode needs a word every other pixel
	assign need_word = !palette_mode || !high_half;
	// Ask in the first half of the pixel, data lands in the second
	assign fetch_request = in_visible_region && !pixel_enable && need_word;
	assign fetch_address = word_address;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			word_address <= '0;
			high_half <= 1'b0;
			read_pending <= 1'b0;
			word_held <= 1'b0;
		end
		else
		begin
			// RAM answers one clk after the grant
			read_pending <= fetch_grant;

			// Raster restarts during vertical sync
			if (!vga_vs)
				word_address <= '0;
			else if (fetch_grant)
				word_address <= word_address + 1'b1;

			// Half-word toggle, cleared outside the visible line
			if (pixel_enable)
			begin
				if (!in_visible_region)
					high_half <= 1'b0;
				else if (palette_mode)
					high_half <= !high_half;
			end

			if (!in_visible_region)
				word_held <= 1'b0;
			else if (read_pending)
				word_held <= 1'b1;
		end
	end

	// Keep the word for the second palette pixel
	always_ff @(posedge clk)
	begin
		if (read_pending)
			held_word <= read_data;
	end

	// Fresh data bypasses the holding register
	assign fetch_word = read_pending ? fb_word_t'(read_data) : held_word;
	assign fetch_word_valid = read_pending || word_held;

endmodule

//--- source/pixel_formatter.sv
module pixel_formatter (
	input logic clk,
	input logic reset,
	input logic pixel_enable,
	input logic in_visible_region,
	input logic vga_hs,
	input logic vga_vs,
	input logic palette_mode,
	input framebuffer_pkg::fb_word_t fetch_word,
	input logic fetch_word_valid,
	input logic palette_write,
	input logic [framebuffer_pkg::PALETTE_INDEX_WIDTH-1:0] palette_index,
	input framebuffer_pkg::rgb565_t palette_color,
	output logic [4:0] red,
	output logic [5:0] green,
	output logic [4:0] blue,
	output logic video_de,
	output logic hs_out,
	output logic vs_out
);
	import framebuffer_pkg::*;

	rgb565_t palette [PALETTE_DEPTH];
	logic high_half;
	logic [PALETTE_INDEX_WIDTH-1:0] pixel_index;
	rgb565_t palette_entry;
	rgb565_t pixel_color;
	logic show_pixel;

	// Host-written lookup table
	always_ff @(posedge clk)
	begin
		if (palette_write)
			palette[palette_index] <= palette_color;
	end

	// Low byte first, then high byte of the same word
	assign pixel_index = high_half ? fetch_word.indexed.second : fetch_word.indexed.first;
	assign palette_entry = palette[pixel_index];
	assign pixel_color = palette_mode ? palette_entry : fetch_word.direct;
	// Black outside the picture
	assign show_pixel = in_visible_region && fetch_word_valid;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			high_half <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
			video_de <= 1'b0;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
		end
		else if (pixel_enable)
		begin
			// Syncs and enable take the same two-clk path as color
			video_de <= in_visible_region;
			hs_out <= vga_hs;
			vs_out <= vga_vs;
			red <= show_pixel ? pixel_color.red : '0;
			green <= show_pixel ? pixel_color.green : '0;
			blue <= show_pixel ? pixel_color.blue : '0;

			// Tracks which byte the next pixel uses
			if (!in_visible_region)
				high_half <= 1'b0;
			else if (palette_mode)
				high_half <= !high_half;
		end
	end

endmodule

//--- source/video_subsystem.sv
module video_subsystem #(
	parameter int FB_ADDR_WIDTH = 19,
	parameter int HSYNC_START = video_timing_pkg::H_FRONT_PORCH,
	parameter int HSYNC_END = HSYNC_START + video_timing_pkg::H_SYNC,
	parameter int HVISIBLE_START = HSYNC_END + video_timing_pkg::H_BACK_PORCH,
	parameter int HVISIBLE_END = HVISIBLE_START + video_timing_pkg::H_VISIBLE,
	parameter int VSYNC_START = video_timing_pkg::V_FRONT_PORCH,
	parameter int VSYNC_END = VSYNC_START + video_timing_pkg::V_SYNC,
	parameter int VVISIBLE_START = VSYNC_END + video_timing_pkg::V_BACK_PORCH,
	parameter int VVISIBLE_END = VVISIBLE_START + video_timing_pkg::V_VISIBLE,
	localparam int HOST_ADDR_WIDTH =
		(FB_ADDR_WIDTH > framebuffer_pkg::PALETTE_INDEX_WIDTH) ?
		FB_ADDR_WIDTH : framebuffer_pkg::PALETTE_INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic host_write,
	input logic host_select,
	input logic [HOST_ADDR_WIDTH-1:0] host_address,
	input logic [framebuffer_pkg::WORD_WIDTH-1:0] host_data,
	input logic palette_mode,
	output logic write_pending,
	output logic [4:0] red,
	output logic [5:0] green,
	output logic [4:0] blue,
	output logic video_de,
	output logic vga_hs,
	output logic vga_vs
);
	import framebuffer_pkg::*;

	// Raw timing, before the formatter delay
	logic pixel_enable;
	logic in_visible_region;
	logic timing_hs;
	logic timing_vs;

	// Frame buffer port traffic
	logic fetch_request;
	logic fetch_grant;
	logic [FB_ADDR_WIDTH-1:0] fetch_address;
	logic write_request;
	logic write_grant;
	logic [FB_ADDR_WIDTH-1:0] write_address;
	logic [WORD_WIDTH-1:0] write_data;
	logic [FB_ADDR_WIDTH-1:0] ram_address;
	logic ram_write_enable;
	logic [WORD_WIDTH-1:0] ram_write_data;
	logic [WORD_WIDTH-1:0] read_data;

	// Toward the formatter
	fb_word_t fetch_word;
	logic fetch_word_valid;
	logic palette_write;
	logic [PALETTE_INDEX_WIDTH-1:0] palette_index;
	rgb565_t palette_color;

	vga_timing_generator #(
		.HSYNC_START(HSYNC_START),
		.HSYNC_END(HSYNC_END),
		.HVISIBLE_START(HVISIBLE_START),
		.HVISIBLE_END(HVISIBLE_END),
		.VSYNC_START(VSYNC_START),
		.VSYNC_END(VSYNC_END),
		.VVISIBLE_START(VVISIBLE_START),
		.VVISIBLE_END(VVISIBLE_END)
	) timing (
		.clk(clk),
		.reset(reset),
		.vga_hs(timing_hs),
		.vga_vs(timing_vs),
		.in_visible_region(in_visible_region),
		.pixel_enable(pixel_enable)
	);

	scanout_fetch #(.FB_ADDR_WIDTH(FB_ADDR_WIDTH)) fetch (
		.clk(clk),
		.reset(reset),
		.pixel_enable(pixel_enable),
		.in_visible_region(in_visible_region),
		.vga_vs(timing_vs),
		.palette_mode(palette_mode),
		.fetch_grant(fetch_grant),
		.read_data(read_data),
		.fetch_request(fetch_request),
		.fetch_address(fetch_address),
		.fetch_word(fetch_word),
		.fetch_word_valid(fetch_word_valid)
	);

	host_write_port #(.FB_ADDR_WIDTH(FB_ADDR_WIDTH)) host (
		.clk(clk),
		.reset(reset),
		.host_write(host_write),
		.host_select(host_select),
		.host_address(host_address),
		.host_data(host_data),
		.write_grant(write_grant),
		.write_pending(write_pending),
		.write_request(write_request),
		.write_address(write_address),
		.write_data(write_data),
		.palette_write(palette_write),
		.palette_index(palette_index),
		.palette_color(palette_color)
	);

	framebuffer_arbiter #(.FB_ADDR_WIDTH(FB_ADDR_WIDTH)) arbiter (
		.fetch_request(fetch_request),
		.fetch_address(fetch_address),
		.write_request(write_request),
		.write_address(write_address),
		.write_data(write_data),
		.fetch_grant(fetch_grant),
		.write_grant(write_grant),
		.ram_address(ram_address),
		.ram_write_enable(ram_write_enable),
		.ram_write_data(ram_write_data)
	);

	framebuffer_ram #(.FB_ADDR_WIDTH(FB_ADDR_WIDTH)) ram (
		.clk(clk),
		.address(ram_address),
		.write_enable(ram_write_enable),
		.write_data(ram_write_data),
		.read_data(read_data)
	);

	pixel_formatter formatter (
		.clk(clk),
		.reset(reset),
		.pixel_enable(pixel_enable),
		.in_visible_region(in_visible_region),
		.vga_hs(timing_hs),
		.vga_vs(timing_vs),
		.palette_mode(palette_mode),
		.fetch_word(fetch_word),
		.fetch_word_valid(fetch_word_valid),
		.palette_write(palette_write),
		.palette_index(palette_index),
		.palette_color(palette_color),
		.red(red),
		.green(green),
		.blue(blue),
		.video_de(video_de),
		.hs_out(vga_hs),
		.vs_out(vga_vs)
	);

endmodule

//--- testbench/video_subsystem_tb.sv
module video_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Tiny raster, 8 pixels by 4 lines
	localparam int FB_ADDR_WIDTH = 6;
	localparam int H_SYNC_START = 2;
	localparam int H_SYNC_END = 4;
	localparam int H_VISIBLE_START = 6;
	localparam int H_VISIBLE_END = 14;
	localparam int V_SYNC_START = 1;
	localparam int V_SYNC_END = 3;
	localparam int V_VISIBLE_START = 4;
	localparam int V_VISIBLE_END = 8;
	localparam int H_PIXELS = H_VISIBLE_END - H_VISIBLE_START;
	localparam int V_LINES = V_VISIBLE_END - V_VISIBLE_START;

	localparam int FB_WORDS = 2 ** FB_ADDR_WIDTH;
	localparam int PALETTE_ENTRIES = 256;
	localparam int RESET_CYCLES = 5;
	// Two clk per pixel, counters run up to the visible end
	localparam int FRAME_CYCLES = 2 * (H_VISIBLE_END + 1) * V_VISIBLE_END;
	// Each host write needs at most three clk
	localparam int LOAD_CYCLES = 3 * (PALETTE_ENTRIES + FB_WORDS);
	localparam int CYCLE_LIMIT = RESET_CYCLES + LOAD_CYCLES + 4 * FRAME_CYCLES;
	// Two direct frames and one palette frame are compared
	localparam int CHECKED_PIXELS = 3 * H_PIXELS * V_LINES;

	logic clk;
	logic reset;
	logic host_write;
	logic host_select;
	logic [7:0] host_address;
	logic [15:0] host_data;
	logic palette_mode;
	logic write_pending;
	logic [4:0] red;
	logic [5:0] green;
	logic [4:0] blue;
	logic video_de;
	logic vga_hs;
	logic vga_vs;
	logic [15:0] pixel_color;

	// Reference picture and lookup table
	logic [15:0] model_memory [FB_WORDS];
	logic [15:0] model_palette [PALETTE_ENTRIES];
	logic [31:0] rng_state = 32'h44b7;

	// Stream bookkeeping, updated on every edge
	logic check_stream = 1'b0;
	logic hs_prev;
	logic vs_prev;
	logic de_prev;
	logic strobe_prev;
	logic [15:0] color_prev;
	logic hs_fall;
	logic vs_fall;
	int unsigned de_count;
	int unsigned line_de;
	int unsigned frame_lines;
	int unsigned pending_run;
	int unsigned pixels_checked;
	int error_count = 0;
	int cycle_count;

	assign pixel_color = {red, green, blue};
	assign hs_fall = hs_prev && !vga_hs;
	assign vs_fall = vs_prev && !vga_vs;

	video_subsystem #(
		.FB_ADDR_WIDTH(FB_ADDR_WIDTH),
		.HSYNC_START(H_SYNC_START),
		.HSYNC_END(H_SYNC_END),
		.HVISIBLE_START(H_VISIBLE_START),
		.HVISIBLE_END(H_VISIBLE_END),
		.VSYNC_START(V_SYNC_START),
		.VSYNC_END(V_SYNC_END),
		.VVISIBLE_START(V_VISIBLE_START),
		.VVISIBLE_END(V_VISIBLE_END)
	) DUT (
		.clk(clk),
		.reset(reset),
		.host_write(host_write),
		.host_select(host_select),
		.host_address(host_address),
		.host_data(host_data),
		.palette_mode(palette_mode),
		.write_pending(write_pending),
		.red(red),
		.green(green),
		.blue(blue),
		.video_de(video_de),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Raster order from word 0, low byte first in palette mode
	function automatic logic [15:0] expected_pixel(input int unsigned pixel, input logic indexed);
		logic [15:0] word;
		logic [7:0] index;
		if (!indexed)
			return model_memory[pixel];
		word = model_memory[pixel / 2];
		index = pixel[0] ? word[15:8] : word[7:0];
		return model_palette[index];
	endfunction

	task automatic report_error(input string signal_name, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("ERR %0t %s expected %0h actual %0h", $time, signal_name, expected, actual);
	endtask

	task automatic next_random(output logic [15:0] value);
		rng_state = xorshift(rng_state);
		value = rng_state[15:0];
	endtask

	// One clk strobe, inputs move 1 ns after the edge
	task automatic strobe_host(input logic select, input logic [7:0] address,
		input logic [15:0] data);
		host_write = 1'b1;
		host_select = select;
		host_address = address;
		host_data = data;
		@(posedge clk);
		#1;
		host_write = 1'b0;
	endtask

	task automatic wait_write_idle();
		while (write_pending)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic load_image();
		logic [15:0] value;
		for (int index = 0; index < PALETTE_ENTRIES; index++)
		begin
			next_random(value);
			wait_write_idle();
			strobe_host(1'b1, index[7:0], value);
			model_palette[index] = value;
		end
		for (int address = 0; address < FB_WORDS; address++)
		begin
			next_random(value);
			wait_write_idle();
			strobe_host(1'b0, address[7:0], value);
			model_memory[address] = value;
		end
		wait_write_idle();
	endtask

	// Returns once the frame's pixel counter has restarted
	task automatic wait_frame_start();
		@(negedge vga_vs);
		@(posedge clk);
		#1;
	endtask

	task automatic print_summary();
		$display("Summary: %0d pixels checked, %0d errors", pixels_checked, error_count);
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			de_prev <= 1'b0;
			strobe_prev <= 1'b0;
			color_prev <= '0;
			de_count <= 0;
			line_de <= 0;
			frame_lines <= 0;
			pending_run <= 0;
			pixels_checked <= 0;
		end
		else
		begin
			hs_prev <= vga_hs;
			vs_prev <= vga_vs;
			de_prev <= video_de;
			color_prev <= pixel_color;
			// Accepted frame buffer strobe
			strobe_prev <= host_write && !host_select && !write_pending;
			pending_run <= write_pending ? pending_run + 1 : 0;
			if (vs_fall)
			begin
				de_count <= 0;
				frame_lines <= 0;
			end
			else
			begin
				if (video_de)
					de_count <= de_count + 1;
				// Rising data enable starts a line
				if (video_de && !de_prev)
					frame_lines <= frame_lines + 1;
			end
			if (hs_fall)
				line_de <= 0;
			else if (video_de)
				line_de <= line_de + 1;
			if (check_stream && video_de && !de_count[0])
				pixels_checked <= pixels_checked + 1;
		end
	end

	// Quiet outputs while reset is held
	reset_de_low: assert property (@(posedge clk) reset |-> !video_de)
		else report_error("video_de", 0, $sampled(video_de));
	reset_pending_low: assert property (@(posedge clk) reset |-> !write_pending)
		else report_error("write_pending", 0, $sampled(write_pending));
	reset_color_black: assert property (@(posedge clk) reset |-> pixel_color == 0)
		else report_error("color", 0, $sampled(pixel_color));

	// Black whenever data enable is low
	blank_color_black: assert property (@(posedge clk) disable iff (reset)
		!video_de |-> pixel_color == 0)
		else report_error("color", 0, $sampled(pixel_color));

	pixel_matches_model: assert property (@(posedge clk) disable iff (reset)
		check_stream && video_de |-> pixel_color == expected_pixel(de_count >> 1, palette_mode))
		else report_error("color",
			expected_pixel($sampled(de_count) >> 1, $sampled(palette_mode)),
			$sampled(pixel_color));

	// Second clk of a pixel repeats the first
	pixel_held_two_clk: assert property (@(posedge clk) disable iff (reset)
		check_stream && video_de && de_count[0] |-> pixel_color == color_prev)
		else report_error("color", $sampled(color_prev), $sampled(pixel_color));

	line_de_length: assert property (@(posedge clk) disable iff (reset)
		hs_fall |-> (line_de == 0 || line_de == 2 * H_PIXELS))
		else report_error("video_de clk per line", 2 * H_PIXELS, $sampled(line_de));

	frame_de_lines: assert property (@(posedge clk) disable iff (reset)
		vs_fall |-> frame_lines == V_LINES)
		else report_error("video_de lines per frame", V_LINES, $sampled(frame_lines));

	pending_raised: assert property (@(posedge clk) disable iff (reset)
		strobe_prev |-> write_pending)
		else report_error("write_pending", 1, $sampled(write_pending));

	// Held write granted within two clk
	pending_cleared: assert property (@(posedge clk) disable iff (reset)
		write_pending |-> pending_run < 2)
		else report_error("write_pending clk high", 2, $sampled(pending_run) + 1);

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d clk cycles, the scenario never reached its end", cycle_count);
		print_summary();
		$display("test failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		host_write = 1'b0;
		host_select = 1'b0;
		host_address = '0;
		host_data = '0;
		palette_mode = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		load_image();

		// First whole frame after loading, direct mode
		wait_frame_start();
		check_stream = 1'b1;

		// Mid-frame write behind the scan position, then one while it waits
		wait (de_count >= 20);
		@(posedge clk);
		#1;
		wait_write_idle();
		strobe_host(1'b0, 8'd3, ~model_memory[3]);
		model_memory[3] = ~model_memory[3];
		strobe_host(1'b0, 8'd5, ~model_memory[5]);
		wait_write_idle();

		// Next frame shows word 3 changed and word 5 untouched
		wait_frame_start();

		// Palette frame from the same words
		wait_frame_start();
		palette_mode = 1'b1;
		wait_frame_start();
		check_stream = 1'b0;

		if (pixels_checked != CHECKED_PIXELS)
		begin
			error_count++;
			$display("Only %0d of %0d pixels were compared against the model",
				pixels_checked, CHECKED_PIXELS);
		end
		print_summary();
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- files.f
source/video_timing_pkg.sv
source/framebuffer_pkg.sv
source/vga_timing_generator.sv
source/framebuffer_ram.sv
source/framebuffer_arbiter.sv
source/host_write_port.sv
source/scanout_fetch.sv
source/pixel_formatter.sv
source/video_subsystem.sv
testbench/video_subsystem_tb.sv
